// File: verilog.f
+incdir+source
+incdir+tb
source/fpu_pkg.sv
source/fpu_op_decoder.sv
source/fpu_operand_unbox.sv
source/fpu_noncomp_unit.sv
source/fpu_result_mux.sv
source/fpu_top.sv
tb/tb_fpu_top.sv

// File: run.sh
#!/bin/sh
# build and run the FPU non-computational testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f verilog.f --top-module tb_fpu_top \
  -Mdir obj_dir -o tb_fpu_top

out=$(./obj_dir/tb_fpu_top)
echo "$out"

# the script's status follows the search for the pass line
echo "$out" | grep -qx "TESTS PASSED"

// File: tb/tb_fpu_model.svh
`ifndef TB_FPU_MODEL_SVH
`define TB_FPU_MODEL_SVH

function automatic int man_bits(bit dp);
  return dp ? `FPU_DP_MAN_W : `FPU_SP_MAN_W;
endfunction

function automatic int exp_bits(bit dp);
  return dp ? `FPU_DP_EXP_W : `FPU_SP_EXP_W;
endfunction

function automatic logic [63:0] field_mask(int bits);
  return (64'd1 << bits) - 64'd1;
endfunction

function automatic logic fp_sign(logic [63:0] v, bit dp);
  return dp ? v[63] : v[31];  // singles sit in the low word
endfunction

function automatic logic [63:0] fp_exp(logic [63:0] v, bit dp);
  return (v >> man_bits(dp)) & field_mask(exp_bits(dp));
endfunction

function automatic logic [63:0] fp_man(logic [63:0] v, bit dp);
  return v & field_mask(man_bits(dp));
endfunction

// one-hot mask in fclass order
function automatic logic [`FPU_CLASS_W-1:0] model_class(logic [63:0] v, bit dp);
  logic [`FPU_CLASS_W-1:0] mask;
  logic [63:0]             e;
  logic [63:0]             m;
  logic                    s;
  int                      idx;
  e = fp_exp(v, dp);
  m = fp_man(v, dp);
  s = fp_sign(v, dp);
  if (e == field_mask(exp_bits(dp)) && m != 64'd0) begin
    idx = (((m >> (man_bits(dp) - 1)) & 64'd1) != 64'd0) ? 9 : 8;
  end else if (e == field_mask(exp_bits(dp))) begin
    idx = s ? 0 : 7;
  end else if (e == 64'd0 && m == 64'd0) begin
    idx = s ? 3 : 4;
  end else if (e == 64'd0) begin
    idx = s ? 2 : 5;
  end else begin
    idx = s ? 1 : 6;
  end
  mask      = '0;
  mask[idx] = 1'b1;
  return mask;
endfunction

// signed integer that orders non-NaN values, both zeros map to 0
function automatic logic signed [64:0] order_key(logic [63:0] v, bit dp);
  logic [64:0] mag;
  mag = {1'b0, v & ~(64'd1 << (dp ? 63 : 31))};
  if (fp_sign(v, dp)) begin
    return -$signed(mag);
  end
  return $signed(mag);
endfunction

function automatic logic [63:0] unbox_single(logic [63:0] r);
  if (r[63:32] == 32'hffffffff) begin
    return {32'd0, r[31:0]};
  end
  return 64'(`FPU_SP_QNAN);  // improperly boxed
endfunction

// expected 64-bit result and flags of one operation
function automatic logic [63:0] model_result(fpu_pkg::fpu_op_e op, bit dp, logic [63:0] rs1,
                                             logic [63:0] rs2, output fpu_pkg::fpu_fflags_t flags);
  logic [63:0]            a;
  logic [63:0]            b;
  logic [63:0]            r;
  logic [63:0]            body;
  logic [63:0]            qnan;
  logic [`FPU_CLASS_W-1:0] ca;
  logic [`FPU_CLASS_W-1:0] cb;
  logic                   a_nan;
  logic                   b_nan;
  logic                   any_snan;
  logic signed [64:0]     ka;
  logic signed [64:0]     kb;
  logic                   is_int;
  int                     sign_pos;
  a        = dp ? rs1 : unbox_single(rs1);
  b        = dp ? rs2 : unbox_single(rs2);
  sign_pos = dp ? 63 : 31;
  body     = a & ~(64'd1 << sign_pos);
  qnan     = dp ? `FPU_DP_QNAN : 64'(`FPU_SP_QNAN);
  ca       = model_class(a, dp);
  cb       = model_class(b, dp);
  a_nan    = ca[8] | ca[9];
  b_nan    = cb[8] | cb[9];
  any_snan = ca[8] | cb[8];
  ka       = order_key(a, dp);
  kb       = order_key(b, dp);
  flags    = '0;
  is_int   = 1'b1;
  r        = '0;
  case (op)
    fpu_pkg::OP_FSGNJ, fpu_pkg::OP_FSGNJN, fpu_pkg::OP_FSGNJX: begin
      is_int = 1'b0;
      if (op == fpu_pkg::OP_FSGNJ) begin
        r = body | (64'(fp_sign(b, dp)) << sign_pos);
      end else if (op == fpu_pkg::OP_FSGNJN) begin
        r = body | (64'(~fp_sign(b, dp)) << sign_pos);
      end else begin
        r = body | (64'(fp_sign(a, dp) ^ fp_sign(b, dp)) << sign_pos);
      end
    end
    fpu_pkg::OP_FMIN, fpu_pkg::OP_FMAX: begin
      is_int   = 1'b0;
      flags.nv = any_snan;
      if (a_nan && b_nan) begin
        r = qnan;
      end else if (a_nan) begin
        r = b;
      end else if (b_nan) begin
        r = a;
      end else if (ka == kb) begin
        r = (fp_sign(a, dp) ^ (op == fpu_pkg::OP_FMAX)) ? a : b;  // -0 below +0
      end else begin
        r = ((ka < kb) ^ (op == fpu_pkg::OP_FMAX)) ? a : b;
      end
    end
    fpu_pkg::OP_FEQ: begin
      flags.nv = any_snan;
      r        = 64'(!(a_nan || b_nan) && ka == kb);
    end
    fpu_pkg::OP_FLT: begin
      flags.nv = a_nan | b_nan;
      r        = 64'(!(a_nan || b_nan) && ka < kb);
    end
    fpu_pkg::OP_FLE: begin
      flags.nv = a_nan | b_nan;
      r        = 64'(!(a_nan || b_nan) && ka <= kb);
    end
    fpu_pkg::OP_FCLASS: r = 64'(ca);
    default: r = '0;
  endcase
  if (!is_int && !dp) begin
    r = {32'hffffffff, r[31:0]};  // nan-box
  end
  return r;
endfunction

`endif

// File: tb/tb_fpu_top.sv
`timescale 1ns/10ps
`default_nettype none
`include "fpu_consts.svh"

module tb_fpu_top;

  localparam int NUM_OPS        = 2000;
  localparam int TIMEOUT_CYCLES = NUM_OPS + 50;

  logic                  i_clk;
  logic                  i_reset_n;
  logic                  valid;
  fpu_pkg::fpu_op_e      op;
  fpu_pkg::fpu_size_e    size;
  logic [`FPU_XLEN-1:0]  rs1;
  logic [`FPU_XLEN-1:0]  rs2;
  logic                  out_valid;
  logic [`FPU_XLEN-1:0]  out_result;
  fpu_pkg::fpu_fflags_t  out_fflags;

  logic [`FPU_XLEN-1:0]  exp_result_q[$];
  fpu_pkg::fpu_fflags_t  exp_fflags_q[$];
  int                    exp_step_q[$];
  string                 exp_desc_q[$];

  int value_errors    = 0;
  int protocol_errors = 0;
  int cycle_count     = 0;
  int step            = 0;

  `include "tb_fpu_model.svh"

  fpu_top u_dut (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_valid_i  (valid),
    .i_op_i     (op),
    .i_size_i   (size),
    .i_rs1_i    (rs1),
    .i_rs2_i    (rs2),
    .o_valid_o  (out_valid),
    .o_result_o (out_result),
    .o_fflags_o (out_fflags)
  );

  always #4 i_clk = ~i_clk;

  always @(posedge i_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TESTS FAILED");
      $finish;
    end
  end

  function automatic bit is_legal(fpu_pkg::fpu_op_e o, fpu_pkg::fpu_size_e s);
    case (o)
      fpu_pkg::OP_FSGNJ, fpu_pkg::OP_FSGNJN, fpu_pkg::OP_FSGNJX,
      fpu_pkg::OP_FMIN, fpu_pkg::OP_FMAX, fpu_pkg::OP_FEQ,
      fpu_pkg::OP_FLT, fpu_pkg::OP_FLE, fpu_pkg::OP_FCLASS:
        return (s == fpu_pkg::SIZE_W) || (s == fpu_pkg::SIZE_DW);
      default: return 1'b0;
    endcase
  endfunction

  // special values mixed with random bits, singles in the low word
  function automatic logic [63:0] random_fp(bit dp);
    int          kind;
    logic        s;
    logic [63:0] e;
    logic [63:0] m;
    logic [63:0] qbit;
    kind = int'($urandom % 12);
    s    = 1'($urandom % 2);
    qbit = 64'd1 << (man_bits(dp) - 1);
    m    = {$urandom, $urandom} & field_mask(man_bits(dp));
    e    = {$urandom, $urandom} & field_mask(exp_bits(dp));
    case (kind)
      0: begin
        e = '0;
        m = '0;
      end
      1: begin
        e = field_mask(exp_bits(dp));  // infinity
        m = '0;
      end
      2: begin
        e = field_mask(exp_bits(dp));
        m = m | qbit;
      end
      3: begin
        e = field_mask(exp_bits(dp));  // signaling, payload kept nonzero
        m = (m & ~qbit) | 64'd1;
      end
      4: begin
        e = '0;
        m = m | 64'd1;
      end
      5, 6: begin
        e = (field_mask(exp_bits(dp)) >> 1) + 64'($urandom % 3);  // narrow range, frequent ties
        m = m & 64'h7;
      end
      default: ;
    endcase
    return (64'(s) << (exp_bits(dp) + man_bits(dp))) | (e << man_bits(dp)) | m;
  endfunction

  function automatic logic [63:0] make_reg(bit dp, logic [63:0] raw);
    logic [31:0] upper;
    if (dp) begin
      return raw;
    end
    if ($urandom % 10 == 0) begin
      upper = $urandom;
      if (upper == 32'hffffffff) begin
        upper = 32'h0;
      end
      return {upper, raw[31:0]};  // broken box
    end
    return {32'hffffffff, raw[31:0]};
  endfunction

  task automatic check_result(input logic [`FPU_XLEN-1:0] got, input logic [`FPU_XLEN-1:0] want,
                              input string desc);
    if (got !== want) begin
      value_errors++;
      $display("ERROR %0t: %s result %h, expected %h", $time, desc, got, want);
    end
  endtask

  task automatic check_fflags(input fpu_pkg::fpu_fflags_t got, input fpu_pkg::fpu_fflags_t want,
                              input string desc);
    if (got !== want) begin
      value_errors++;
      $display("ERROR %0t: %s fflags %b, expected %b", $time, desc, got, want);
    end
  endtask

  // runs on the falling edge, outputs are settled by then
  task automatic check_outputs();
    string desc;
    int    issued;
    step++;
    if (out_valid) begin
      if (exp_result_q.size() == 0) begin
        protocol_errors++;
        $display("o_valid_o was high at %0t with no operation outstanding", $time);
      end else begin
        issued = exp_step_q.pop_front();
        desc   = exp_desc_q.pop_front();
        if (issued != step - 1) begin
          protocol_errors++;
          $display("result for %s at %0t did not come one cycle after issue", desc, $time);
        end
        check_result(out_result, exp_result_q.pop_front(), desc);
        check_fflags(out_fflags, exp_fflags_q.pop_front(), desc);
      end
    end else if (exp_step_q.size() != 0 && exp_step_q[0] < step) begin
      protocol_errors++;
      $display("no result at %0t for %s", $time, exp_desc_q[0]);
      void'(exp_step_q.pop_front());
      void'(exp_desc_q.pop_front());
      void'(exp_result_q.pop_front());
      void'(exp_fflags_q.pop_front());
    end
  endtask

  task automatic drive_slot();
    logic [4:0]           op_code;
    bit                   dp;
    fpu_pkg::fpu_fflags_t flags;
    logic [63:0]          exp_val;
    if ($urandom % 16 < 14) begin
      op_code = 5'($urandom % 9);
    end else begin
      op_code = 5'(9 + $urandom % 23);  // illegal codes
    end
    op = fpu_pkg::fpu_op_e'(op_code);
    if ($urandom % 16 < 15) begin
      size = fpu_pkg::fpu_size_e'(2'($urandom % 2));
    end else begin
      size = fpu_pkg::fpu_size_e'(2'(2 + $urandom % 2));  // reserved
    end
    dp    = (size == fpu_pkg::SIZE_DW);
    rs1   = make_reg(dp, random_fp(dp));
    rs2   = ($urandom % 8 == 0) ? rs1 : make_reg(dp, random_fp(dp));
    valid = ($urandom % 8) != 0;
    if (valid && is_legal(op, size)) begin
      exp_val = model_result(op, dp, rs1, rs2, flags);
      exp_result_q.push_back(exp_val);
      exp_fflags_q.push_back(flags);
      exp_step_q.push_back(step);
      exp_desc_q.push_back($sformatf("op %0d size %0d rs1 %h rs2 %h", op, size, rs1, rs2));
    end
  endtask

  initial begin
    i_clk     = 1'b0;
    i_reset_n = 1'b0;
    valid     = 1'b0;
    op        = fpu_pkg::OP_FSGNJ;
    size      = fpu_pkg::SIZE_W;
    rs1       = '0;
    rs2       = '0;
    void'($urandom(32'hea9b));

    repeat (2) @(posedge i_clk);
    @(negedge i_clk);
    i_reset_n = 1'b1;
    if (out_valid !== 1'b0) begin
      protocol_errors++;
      $display("o_valid_o is not low right after reset");
    end

    for (int slot = 0; slot < NUM_OPS; slot++) begin
      drive_slot();
      @(negedge i_clk);
      check_outputs();
    end

    valid = 1'b0;
    repeat (2) begin
      @(negedge i_clk);
      check_outputs();
    end
    if (exp_result_q.size() != 0) begin
      protocol_errors++;
      $display("%0d expected results never appeared", exp_result_q.size());
    end

    $display("errors: %0d value mismatches, %0d protocol errors", value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: source/fpu_top.sv
`timescale 1ns/10ps
`default_nettype none
`include "fpu_consts.svh"

module fpu_top (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  logic                 i_valid_i,
  input  fpu_pkg::fpu_op_e     i_op_i,
  input  fpu_pkg::fpu_size_e   i_size_i,
  input  logic [`FPU_XLEN-1:0] i_rs1_i,
  input  logic [`FPU_XLEN-1:0] i_rs2_i,
  output logic                 o_valid_o,
  output logic [`FPU_XLEN-1:0] o_result_o,
  output fpu_pkg::fpu_fflags_t o_fflags_o
);

  localparam int SP_W = 1 + `FPU_SP_EXP_W + `FPU_SP_MAN_W;

  logic                   w_sp_valid;
  logic                   w_dp_valid;
  fpu_pkg::noncomp_func_e w_func;
  logic [SP_W-1:0]        w_sp_a;
  logic [SP_W-1:0]        w_sp_b;

  logic                   w_sp_out_valid;
  logic [SP_W-1:0]        w_sp_result;
  fpu_pkg::fpu_fflags_t   w_sp_fflags;
  logic                   w_sp_is_int;
  logic                   w_dp_out_valid;
  logic [`FPU_XLEN-1:0]   w_dp_result;
  fpu_pkg::fpu_fflags_t   w_dp_fflags;
  logic                   w_dp_is_int;

  fpu_op_decoder u_decoder (
    .i_valid_i    (i_valid_i),
    .i_op_i       (i_op_i),
    .i_size_i     (i_size_i),
    .o_sp_valid_o (w_sp_valid),
    .o_dp_valid_o (w_dp_valid),
    .o_func_o     (w_func)
  );

  fpu_operand_unbox u_unbox (
    .i_rs1_i  (i_rs1_i),
    .i_rs2_i  (i_rs2_i),
    .o_sp_a_o (w_sp_a),
    .o_sp_b_o (w_sp_b)
  );

  fpu_noncomp_unit #(
    .EXP_W (`FPU_SP_EXP_W),
    .MAN_W (`FPU_SP_MAN_W),
    .QNAN  (`FPU_SP_QNAN)
  ) u_sp_unit (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_valid_i  (w_sp_valid),
    .i_func_i   (w_func),
    .i_a_i      (w_sp_a),
    .i_b_i      (w_sp_b),
    .o_valid_o  (w_sp_out_valid),
    .o_result_o (w_sp_result),
    .o_fflags_o (w_sp_fflags),
    .o_is_int_o (w_sp_is_int)
  );

  fpu_noncomp_unit #(
    .EXP_W (`FPU_DP_EXP_W),
    .MAN_W (`FPU_DP_MAN_W),
    .QNAN  (`FPU_DP_QNAN)
  ) u_dp_unit (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_valid_i  (w_dp_valid),
    .i_func_i   (w_func),
    .i_a_i      (i_rs1_i),     // doubles need no unboxing
    .i_b_i      (i_rs2_i),
    .o_valid_o  (w_dp_out_valid),
    .o_result_o (w_dp_result),
    .o_fflags_o (w_dp_fflags),
    .o_is_int_o (w_dp_is_int)
  );

  fpu_result_mux u_result_mux (
    .i_sp_valid_i  (w_sp_out_valid),
    .i_sp_result_i (w_sp_result),
    .i_sp_fflags_i (w_sp_fflags),
    .i_sp_is_int_i (w_sp_is_int),
    .i_dp_valid_i  (w_dp_out_valid),
    .i_dp_result_i (w_dp_result),
    .i_dp_fflags_i (w_dp_fflags),
    .i_dp_is_int_i (w_dp_is_int),
    .o_valid_o     (o_valid_o),
    .o_result_o    (o_result_o),
    .o_fflags_o    (o_fflags_o)
  );

endmodule

`default_nettype wire

// File: source/fpu_result_mux.sv
`timescale 1ns/10ps
`default_nettype none
`include "fpu_consts.svh"

module fpu_result_mux (
  input  logic                                 i_sp_valid_i,
  input  logic [`FPU_SP_EXP_W+`FPU_SP_MAN_W:0] i_sp_result_i,
  input  fpu_pkg::fpu_fflags_t                 i_sp_fflags_i,
  input  logic                                 i_sp_is_int_i,
  input  logic                                 i_dp_valid_i,
  input  logic [`FPU_XLEN-1:0]                 i_dp_result_i,
  input  fpu_pkg::fpu_fflags_t                 i_dp_fflags_i,
  input  logic                                 i_dp_is_int_i,
  output logic                                 o_valid_o,
  output logic [`FPU_XLEN-1:0]                 o_result_o,
  output fpu_pkg::fpu_fflags_t                 o_fflags_o
);

  localparam int SP_W  = 1 + `FPU_SP_EXP_W + `FPU_SP_MAN_W;
  localparam int PAD_W = `FPU_XLEN - SP_W;

  assign o_valid_o = i_sp_valid_i | i_dp_valid_i;

  always_comb begin
    o_result_o = '0;
    o_fflags_o = '0;
    if (i_sp_valid_i) begin
      o_result_o = {{PAD_W{~i_sp_is_int_i}}, i_sp_result_i};  // nan-box floats only
      o_fflags_o = i_sp_fflags_i;
    end else if (i_dp_valid_i) begin
      // integer results fit the low word
      o_result_o = i_dp_is_int_i ? {{PAD_W{1'b0}}, i_dp_result_i[SP_W-1:0]} : i_dp_result_i;
      o_fflags_o = i_dp_fflags_i;
    end
  end

  // both units share one latency, so decoder exclusivity must carry through
  always_comb begin
    assert (!(i_sp_valid_i && i_dp_valid_i))
      else $error("sp and dp results collide in the merge");
  end

endmodule

`default_nettype wire

// File: source/fpu_noncomp_unit.sv
`timescale 1ns/10ps
`default_nettype none
`include "fpu_consts.svh"

module fpu_noncomp_unit #(
  parameter int                   EXP_W = `FPU_SP_EXP_W,
  parameter int                   MAN_W = `FPU_SP_MAN_W,
  parameter logic [EXP_W+MAN_W:0] QNAN  = `FPU_SP_QNAN
) (
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  input  logic                   i_valid_i,
  input  fpu_pkg::noncomp_func_e i_func_i,
  input  logic [EXP_W+MAN_W:0]   i_a_i,
  input  logic [EXP_W+MAN_W:0]   i_b_i,
  output logic                   o_valid_o,
  output logic [EXP_W+MAN_W:0]   o_result_o,
  output fpu_pkg::fpu_fflags_t   o_fflags_o,
  output logic                   o_is_int_o
);

  localparam int W = 1 + EXP_W + MAN_W;

  logic                    r_valid;
  fpu_pkg::noncomp_func_e  r_func;
  logic [W-1:0]            r_a;
  logic [W-1:0]            r_b;

  logic [`FPU_CLASS_W-1:0] w_class_a;
  logic [`FPU_CLASS_W-1:0] w_class_b;
  logic                    w_a_nan;
  logic                    w_b_nan;
  logic                    w_any_nan;
  logic                    w_any_snan;
  logic                    w_both_zero;
  logic                    w_mag_lt;
  logic                    w_mag_gt;
  logic                    w_lt_total;
  logic                    w_lt;
  logic                    w_eq;

  // riscv fclass bit order
  function automatic logic [`FPU_CLASS_W-1:0] classify(input logic [W-1:0] v);
    logic                    sign;
    logic                    exp_ones;
    logic                    exp_zero;
    logic                    man_zero;
    logic [`FPU_CLASS_W-1:0] mask;
    sign     = v[W-1];
    exp_ones = &v[W-2:MAN_W];
    exp_zero = ~|v[W-2:MAN_W];
    man_zero = ~|v[MAN_W-1:0];
    mask[0]  = sign & exp_ones & man_zero;         // -inf
    mask[1]  = sign & ~exp_ones & ~exp_zero;       // -normal
    mask[2]  = sign & exp_zero & ~man_zero;        // -subnormal
    mask[3]  = sign & exp_zero & man_zero;         // -0
    mask[4]  = ~sign & exp_zero & man_zero;        // +0
    mask[5]  = ~sign & exp_zero & ~man_zero;
    mask[6]  = ~sign & ~exp_ones & ~exp_zero;
    mask[7]  = ~sign & exp_ones & man_zero;        // +inf
    mask[8]  = exp_ones & ~man_zero & ~v[MAN_W-1]; // signaling nan
    mask[9]  = exp_ones & ~man_zero & v[MAN_W-1];  // quiet nan
    return mask;
  endfunction

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= 1'b0;
    end else begin
      r_valid <= i_valid_i;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid_i) begin
      r_func <= i_func_i;
      r_a    <= i_a_i;
      r_b    <= i_b_i;
    end
  end

  assign w_class_a   = classify(r_a);
  assign w_class_b   = classify(r_b);
  assign w_a_nan     = w_class_a[8] | w_class_a[9];
  assign w_b_nan     = w_class_b[8] | w_class_b[9];
  assign w_any_nan   = w_a_nan | w_b_nan;
  assign w_any_snan  = w_class_a[8] | w_class_b[8];
  assign w_both_zero = (w_class_a[3] | w_class_a[4]) & (w_class_b[3] | w_class_b[4]);

  // sign-magnitude order with -0 below +0
  assign w_mag_lt   = r_a[W-2:0] < r_b[W-2:0];
  assign w_mag_gt   = r_a[W-2:0] > r_b[W-2:0];
  assign w_lt_total = (r_a[W-1] != r_b[W-1]) ? r_a[W-1] :
                      r_a[W-1]               ? w_mag_gt : w_mag_lt;

  assign w_lt = w_lt_total & ~w_both_zero & ~w_any_nan;  // zeros compare equal in ieee
  assign w_eq = ((r_a == r_b) | w_both_zero) & ~w_any_nan;

  always_comb begin
    o_result_o = '0;
    o_fflags_o = '0;
    o_is_int_o = 1'b0;
    case (r_func)
      fpu_pkg::FN_SGNJ:  o_result_o = {r_b[W-1], r_a[W-2:0]};
      fpu_pkg::FN_SGNJN: o_result_o = {~r_b[W-1], r_a[W-2:0]};
      fpu_pkg::FN_SGNJX: o_result_o = {r_a[W-1] ^ r_b[W-1], r_a[W-2:0]};
      fpu_pkg::FN_MIN, fpu_pkg::FN_MAX: begin
        if (w_a_nan && w_b_nan) begin
          o_result_o = QNAN;
        end else if (w_a_nan) begin
          o_result_o = r_b;
        end else if (w_b_nan) begin
          o_result_o = r_a;
        end else begin
          o_result_o = (w_lt_total ^ (r_func == fpu_pkg::FN_MAX)) ? r_a : r_b;
        end
        o_fflags_o.nv = w_any_snan;
      end
      fpu_pkg::FN_EQ: begin
        o_result_o    = W'(w_eq);
        o_fflags_o.nv = w_any_snan;  // quiet compare
        o_is_int_o    = 1'b1;
      end
      fpu_pkg::FN_LT, fpu_pkg::FN_LE: begin
        o_result_o    = (r_func == fpu_pkg::FN_LE) ? W'(w_lt | w_eq) : W'(w_lt);
        o_fflags_o.nv = w_any_nan;   // signaling compare
        o_is_int_o    = 1'b1;
      end
      fpu_pkg::FN_CLASS: begin
        o_result_o = W'(w_class_a);
        o_is_int_o = 1'b1;
      end
      default: ;
    endcase
  end

  assign o_valid_o = r_valid;

  // every operand falls in exactly one class
  a_class_onehot: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
      o_valid_o |-> ($onehot(w_class_a) && $onehot(w_class_b))
  ) else $error("operand classify mask is not one-hot");

endmodule

`default_nettype wire

// File: source/fpu_operand_unbox.sv
`timescale 1ns/10ps
`default_nettype none
`include "fpu_consts.svh"

module fpu_operand_unbox (
  input  fpu_pkg::fp_operand_u                   i_rs1_i,
  input  fpu_pkg::fp_operand_u                   i_rs2_i,
  output logic [`FPU_SP_EXP_W+`FPU_SP_MAN_W:0]   o_sp_a_o,
  output logic [`FPU_SP_EXP_W+`FPU_SP_MAN_W:0]   o_sp_b_o
);

  // a single held in a wider register is valid only with an all-ones upper half,
  // anything else reads as the canonical NaN
  function automatic logic [`FPU_SP_EXP_W+`FPU_SP_MAN_W:0] unbox(
    input fpu_pkg::fp_operand_u r
  );
    if (&r.sp.box) begin
      return {r.sp.sign, r.sp.exp, r.sp.man};
    end
    return `FPU_SP_QNAN;  // broken box
  endfunction

  assign o_sp_a_o = unbox(i_rs1_i);
  assign o_sp_b_o = unbox(i_rs2_i);

endmodule

`default_nettype wire

// File: source/fpu_op_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module fpu_op_decoder (
  input  logic                   i_valid_i,
  input  fpu_pkg::fpu_op_e       i_op_i,
  input  fpu_pkg::fpu_size_e     i_size_i,
  output logic                   o_sp_valid_o,
  output logic                   o_dp_valid_o,
  output fpu_pkg::noncomp_func_e o_func_o
);

  logic w_legal_op;

  always_comb begin
    w_legal_op = 1'b1;
    case (i_op_i)
      fpu_pkg::OP_FSGNJ:  o_func_o = fpu_pkg::FN_SGNJ;
      fpu_pkg::OP_FSGNJN: o_func_o = fpu_pkg::FN_SGNJN;
      fpu_pkg::OP_FSGNJX: o_func_o = fpu_pkg::FN_SGNJX;
      fpu_pkg::OP_FMIN:   o_func_o = fpu_pkg::FN_MIN;
      fpu_pkg::OP_FMAX:   o_func_o = fpu_pkg::FN_MAX;
      fpu_pkg::OP_FEQ:    o_func_o = fpu_pkg::FN_EQ;
      fpu_pkg::OP_FLT:    o_func_o = fpu_pkg::FN_LT;
      fpu_pkg::OP_FLE:    o_func_o = fpu_pkg::FN_LE;
      fpu_pkg::OP_FCLASS: o_func_o = fpu_pkg::FN_CLASS;
      default: begin
        w_legal_op = 1'b0;              // dropped silently
        o_func_o   = fpu_pkg::FN_SGNJ;
      end
    endcase

    // steer the strobe by operand size
    o_sp_valid_o = i_valid_i & w_legal_op & (i_size_i == fpu_pkg::SIZE_W);
    o_dp_valid_o = i_valid_i & w_legal_op & (i_size_i == fpu_pkg::SIZE_DW);
  end

endmodule

`default_nettype wire

// File: source/fpu_pkg.sv
`default_nettype none
`include "fpu_consts.svh"

package fpu_pkg;

  typedef enum logic [4:0] {
    OP_FSGNJ  = 5'd0,
    OP_FSGNJN = 5'd1,
    OP_FSGNJX = 5'd2,
    OP_FMIN   = 5'd3,
    OP_FMAX   = 5'd4,
    OP_FEQ    = 5'd5,
    OP_FLT    = 5'd6,
    OP_FLE    = 5'd7,
    OP_FCLASS = 5'd8   // codes above are illegal
  } fpu_op_e;

  typedef enum logic [1:0] {
    SIZE_W     = 2'b00,
    SIZE_DW    = 2'b01,
    SIZE_RSVD2 = 2'b10,
    SIZE_RSVD3 = 2'b11
  } fpu_size_e;

  // unit function, one per supported operation
  typedef enum logic [3:0] {
    FN_SGNJ  = 4'd0,
    FN_SGNJN = 4'd1,
    FN_SGNJX = 4'd2,
    FN_MIN   = 4'd3,
    FN_MAX   = 4'd4,
    FN_EQ    = 4'd5,
    FN_LT    = 4'd6,
    FN_LE    = 4'd7,
    FN_CLASS = 4'd8
  } noncomp_func_e;

  typedef struct packed {
    logic                     sign;
    logic [`FPU_DP_EXP_W-1:0] exp;
    logic [`FPU_DP_MAN_W-1:0] man;
  } fp_dp_view_t;

  typedef struct packed {
    logic [`FPU_XLEN-(1+`FPU_SP_EXP_W+`FPU_SP_MAN_W)-1:0] box;  // all ones when boxed
    logic                                                 sign;
    logic [`FPU_SP_EXP_W-1:0]                             exp;
    logic [`FPU_SP_MAN_W-1:0]                             man;
  } fp_sp_view_t;

  // one register, read as a double or as a boxed single
  typedef union packed {
    fp_dp_view_t dp;
    fp_sp_view_t sp;
  } fp_operand_u;

  typedef struct packed {
    logic nv;  // invalid
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } fpu_fflags_t;

endpackage

`default_nettype wire

// File: source/fpu_consts.svh
`ifndef FPU_CONSTS_SVH
`define FPU_CONSTS_SVH

// register width of the FP register file
`define FPU_XLEN      64

// single precision fields
`define FPU_SP_EXP_W  8
`define FPU_SP_MAN_W  23

// double precision fields
`define FPU_DP_EXP_W  11
`define FPU_DP_MAN_W  52

// canonical quiet NaNs
`define FPU_SP_QNAN   32'h7fc00000
`define FPU_DP_QNAN   64'h7ff8000000000000

`define FPU_CLASS_W   10  // fclass one-hot mask width

`endif
